//--- verilog/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int REG_COUNT   = 32;
    localparam int ISSUE_WIDTH = 2;                 // master + slave
    localparam int RD_PORTS    = 2 * ISSUE_WIDTH;   // rs and rt for each slot

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;

    // primary opcode field, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LUI     = 6'h0F;

    // funct field of SPECIAL, instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;
    localparam logic [5:0] FN_SLTU = 6'h2B;

    // alu operation carried with each issued instruction
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_LUI  = 4'd9,
        ALU_PASS = 4'd15    // nop, result not written
    } aluOp_t;

endpackage

`default_nettype wire

//--- verilog/pipeTypesPkg.sv
`default_nettype none

package pipeTypesPkg;

    import cpuIsaPkg::*;

    // one instruction offered by fetch
    typedef struct packed {
        word_t pc;
        word_t instr;
    } instSlot_t;

    // decoded, operands already forwarded
    typedef struct packed {
        logic       valid;
        aluOp_t     aluOp;
        word_t      opA;
        word_t      opB;        // register or extended immediate
        logic [4:0] shamt;
        regAddr_t   dest;
        logic       regWrite;
        word_t      pc;
    } laneCmd_t;

    // execute stage output, pc rides along for the trace
    typedef struct packed {
        logic     valid;
        logic     regWrite;
        regAddr_t dest;
        word_t    value;
        word_t    pc;
    } laneResult_t;

    typedef struct packed {
        word_t      pc;
        logic [3:0] wen;
        regAddr_t   wnum;
        word_t      wdata;
    } wbTrace_t;

endpackage

`default_nettype wire

//--- verilog/issueUnit.sv
`timescale 1ns/1ps
`default_nettype none

module issueUnit (
    input  logic                                                  clk_i,
    input  logic                                                  rstN_i,
    input  pipeTypesPkg::instSlot_t   [cpuIsaPkg::ISSUE_WIDTH-1:0] pairSlots_i,
    input  logic                                                  pairValid_i,
    output logic                                                  pairAccept_o,
    input  pipeTypesPkg::laneResult_t [cpuIsaPkg::ISSUE_WIDTH-1:0] exResult_i,
    output cpuIsaPkg::regAddr_t       [cpuIsaPkg::RD_PORTS-1:0]    rdAddr_o,
    input  cpuIsaPkg::word_t          [cpuIsaPkg::RD_PORTS-1:0]    rdData_i,
    output pipeTypesPkg::laneCmd_t    [cpuIsaPkg::ISSUE_WIDTH-1:0] laneCmd_o
);
    import cpuIsaPkg::*;
    import pipeTypesPkg::*;

    typedef struct packed {
        aluOp_t   op;
        regAddr_t dest;
        logic     regWrite;
        logic     useRs;
        logic     useRt;
        logic     useImm;
        word_t    imm;
    } decInfo_t;

    decInfo_t dec [ISSUE_WIDTH];
    word_t [RD_PORTS-1:0] srcVal;   // register operands after forwarding
    logic masterDone;               // first half of a split pair already issued
    logic slaveDep;
    logic split;

    // decode, port 2*s is rs and 2*s+1 is rt of slot s
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            rdAddr_o[2*s]   = pairSlots_i[s].instr[25:21];
            rdAddr_o[2*s+1] = pairSlots_i[s].instr[20:16];
            dec[s].op       = ALU_PASS;
            dec[s].dest     = pairSlots_i[s].instr[20:16];  // rt for i-type
            dec[s].regWrite = 1'b0;
            dec[s].useRs    = 1'b0;
            dec[s].useRt    = 1'b0;
            dec[s].useImm   = 1'b1;
            dec[s].imm      = {16'b0, pairSlots_i[s].instr[15:0]};
            case (pairSlots_i[s].instr[31:26])
                OP_SPECIAL: begin
                    dec[s].dest     = pairSlots_i[s].instr[15:11];
                    dec[s].regWrite = 1'b1;
                    dec[s].useRs    = 1'b1;
                    dec[s].useRt    = 1'b1;
                    dec[s].useImm   = 1'b0;
                    case (pairSlots_i[s].instr[5:0])
                        FN_ADDU: dec[s].op = ALU_ADD;
                        FN_SUBU: dec[s].op = ALU_SUB;
                        FN_AND:  dec[s].op = ALU_AND;
                        FN_OR:   dec[s].op = ALU_OR;
                        FN_XOR:  dec[s].op = ALU_XOR;
                        FN_SLT:  dec[s].op = ALU_SLT;
                        FN_SLTU: dec[s].op = ALU_SLTU;
                        FN_SLL: begin
                            dec[s].op    = ALU_SLL;
                            dec[s].useRs = 1'b0;    // shifts read rt only
                        end
                        FN_SRL: begin
                            dec[s].op    = ALU_SRL;
                            dec[s].useRs = 1'b0;
                        end
                        default: begin
                            dec[s].regWrite = 1'b0;
                            dec[s].useRs    = 1'b0;
                            dec[s].useRt    = 1'b0;
                        end
                    endcase
                end
                OP_ADDIU: begin
                    dec[s].op       = ALU_ADD;
                    dec[s].regWrite = 1'b1;
                    dec[s].useRs    = 1'b1;
                    dec[s].imm      = {{16{pairSlots_i[s].instr[15]}},
                                       pairSlots_i[s].instr[15:0]};
                end
                OP_ANDI: begin
                    dec[s].op       = ALU_AND;
                    dec[s].regWrite = 1'b1;
                    dec[s].useRs    = 1'b1;
                end
                OP_ORI: begin
                    dec[s].op       = ALU_OR;
                    dec[s].regWrite = 1'b1;
                    dec[s].useRs    = 1'b1;
                end
                OP_XORI: begin
                    dec[s].op       = ALU_XOR;
                    dec[s].regWrite = 1'b1;
                    dec[s].useRs    = 1'b1;
                end
                OP_LUI: begin
                    dec[s].op       = ALU_LUI;
                    dec[s].regWrite = 1'b1;
                end
                default: ;  // unsupported, stays a nop
            endcase
        end
    end

    // slave reads what the master writes in the same pair
    assign slaveDep = dec[0].regWrite && (dec[0].dest != '0) &&
                      ((dec[1].useRs && (rdAddr_o[2] == dec[0].dest)) ||
                       (dec[1].useRt && (rdAddr_o[3] == dec[0].dest)));
    assign split        = pairValid_i && !masterDone && slaveDep;
    assign pairAccept_o = !split;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            masterDone <= 1'b0;
        end else begin
            masterDone <= split;    // slave half issues next cycle
        end
    end

    // execute results over register file, lane 1 is younger so it goes last
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            srcVal[p] = rdData_i[p];
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (exResult_i[l].valid && exResult_i[l].regWrite &&
                    (exResult_i[l].dest == rdAddr_o[p])) begin
                    srcVal[p] = exResult_i[l].value;
                end
            end
            if (rdAddr_o[p] == '0) begin
                srcVal[p] = '0;
            end
        end
    end

    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            laneCmd_o[s].aluOp    = dec[s].op;
            laneCmd_o[s].opA      = srcVal[2*s];
            laneCmd_o[s].opB      = dec[s].useImm ? dec[s].imm : srcVal[2*s+1];
            laneCmd_o[s].shamt    = pairSlots_i[s].instr[10:6];
            laneCmd_o[s].dest     = dec[s].dest;
            laneCmd_o[s].regWrite = dec[s].regWrite;
            laneCmd_o[s].pc       = pairSlots_i[s].pc;
        end
        laneCmd_o[0].valid = pairValid_i && !masterDone;
        laneCmd_o[1].valid = pairValid_i && !split;   // bubble while master goes alone
    end

    // a split costs exactly one cycle
    acceptGap: assert property (@(posedge clk_i) disable iff (!rstN_i)
        !pairAccept_o |=> pairAccept_o);

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                                            clk_i,
    input  logic                                            rstN_i,
    input  cpuIsaPkg::regAddr_t [cpuIsaPkg::RD_PORTS-1:0]    rdAddr_i,
    output cpuIsaPkg::word_t    [cpuIsaPkg::RD_PORTS-1:0]    rdData_o,
    input  logic                [cpuIsaPkg::ISSUE_WIDTH-1:0] wrEn_i,
    input  cpuIsaPkg::regAddr_t [cpuIsaPkg::ISSUE_WIDTH-1:0] wrAddr_i,
    input  cpuIsaPkg::word_t    [cpuIsaPkg::ISSUE_WIDTH-1:0] wrData_i
);
    import cpuIsaPkg::*;

    word_t regs [REG_COUNT-1:1];    // r0 has no storage

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            for (int r = 1; r < REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // port 1 is the slave, its write lands last
            for (int w = 0; w < ISSUE_WIDTH; w++) begin
                if (wrEn_i[w] && (wrAddr_i[w] != '0)) begin
                    regs[wrAddr_i[w]] <= wrData_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            rdData_o[p] = '0;
            if (rdAddr_i[p] != '0) begin
                rdData_o[p] = regs[rdAddr_i[p]];
                for (int w = 0; w < ISSUE_WIDTH; w++) begin  // write-through
                    if (wrEn_i[w] && (wrAddr_i[w] == rdAddr_i[p])) begin
                        rdData_o[p] = wrData_i[w];
                    end
                end
            end
        end
    end

    for (genvar p = 0; p < RD_PORTS; p++) begin : gZeroChk
        zeroRead: assert property (@(posedge clk_i)
            (rdAddr_i[p] == '0) |-> (rdData_o[p] == '0));
    end

endmodule

`default_nettype wire

//--- verilog/aluLane.sv
`timescale 1ns/1ps
`default_nettype none

module aluLane (
    input  logic                      clk_i,
    input  logic                      rstN_i,
    input  pipeTypesPkg::laneCmd_t    cmd_i,
    output pipeTypesPkg::laneResult_t result_o
);
    import cpuIsaPkg::*;
    import pipeTypesPkg::*;

    laneCmd_t cmdQ;     // execute register
    word_t    aluOut;
    logic     ltSigned;
    logic     ltUnsigned;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            cmdQ.valid <= 1'b0;     // payload just holds
        end else begin
            cmdQ <= cmd_i;
        end
    end

    assign ltSigned   = $signed(cmdQ.opA) < $signed(cmdQ.opB);
    assign ltUnsigned = cmdQ.opA < cmdQ.opB;

    always_comb begin
        case (cmdQ.aluOp)
            ALU_ADD:  aluOut = cmdQ.opA + cmdQ.opB;   // wraps, no overflow trap
            ALU_SUB:  aluOut = cmdQ.opA - cmdQ.opB;
            ALU_AND:  aluOut = cmdQ.opA & cmdQ.opB;
            ALU_OR:   aluOut = cmdQ.opA | cmdQ.opB;
            ALU_XOR:  aluOut = cmdQ.opA ^ cmdQ.opB;
            ALU_SLT:  aluOut = {{(DATA_W-1){1'b0}}, ltSigned};
            ALU_SLTU: aluOut = {{(DATA_W-1){1'b0}}, ltUnsigned};
            ALU_SLL:  aluOut = cmdQ.opB << cmdQ.shamt;
            ALU_SRL:  aluOut = cmdQ.opB >> cmdQ.shamt;  // logical
            ALU_LUI:  aluOut = {cmdQ.opB[15:0], 16'b0};
            default:  aluOut = cmdQ.opA;
        endcase
    end

    assign result_o.valid    = cmdQ.valid;
    assign result_o.regWrite = cmdQ.regWrite;
    assign result_o.dest     = cmdQ.dest;
    assign result_o.value    = aluOut;
    assign result_o.pc       = cmdQ.pc;

    // results only come from a command issued on the previous edge
    execFromIssue: assert property (@(posedge clk_i) disable iff (!rstN_i)
        result_o.valid |-> $past(cmd_i.valid));

endmodule

`default_nettype wire

//--- verilog/writebackUnit.sv
`timescale 1ns/1ps
`default_nettype none

module writebackUnit (
    input  logic                                                  clk_i,
    input  logic                                                  rstN_i,
    input  pipeTypesPkg::laneResult_t [cpuIsaPkg::ISSUE_WIDTH-1:0] exResult_i,
    output logic                      [cpuIsaPkg::ISSUE_WIDTH-1:0] wrEn_o,
    output cpuIsaPkg::regAddr_t       [cpuIsaPkg::ISSUE_WIDTH-1:0] wrAddr_o,
    output cpuIsaPkg::word_t          [cpuIsaPkg::ISSUE_WIDTH-1:0] wrData_o,
    output pipeTypesPkg::wbTrace_t    [cpuIsaPkg::ISSUE_WIDTH-1:0] debugWb_o
);
    import cpuIsaPkg::*;
    import pipeTypesPkg::*;

    laneResult_t [ISSUE_WIDTH-1:0] wbQ;

    always_ff @(posedge clk_i) begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (!rstN_i) begin
                wbQ[l].valid <= 1'b0;
            end else begin
                wbQ[l] <= exResult_i[l];
            end
        end
    end

    always_comb begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            wrEn_o[l]          = wbQ[l].valid && wbQ[l].regWrite;
            wrAddr_o[l]        = wbQ[l].dest;
            wrData_o[l]        = wbQ[l].value;
            debugWb_o[l].pc    = wbQ[l].pc;
            debugWb_o[l].wen   = {4{wrEn_o[l] && (wbQ[l].dest != '0)}};  // r0 writes hidden
            debugWb_o[l].wnum  = wbQ[l].dest;
            debugWb_o[l].wdata = wbQ[l].value;
        end
    end

    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : gTraceChk
        noZeroTrace: assert property (@(posedge clk_i) disable iff (!rstN_i)
            (|debugWb_o[l].wen) |-> ($past(exResult_i[l].dest) != '0));
    end

endmodule

`default_nettype wire

//--- verilog/dualIssueCore.sv
`timescale 1ns/1ps
`default_nettype none

module dualIssueCore (
    input  logic                                                clk_i,
    input  logic                                                rstN_i,
    input  pipeTypesPkg::instSlot_t [cpuIsaPkg::ISSUE_WIDTH-1:0] pairSlots_i,
    input  logic                                                pairValid_i,
    output logic                                                pairAccept_o,
    output pipeTypesPkg::wbTrace_t  [cpuIsaPkg::ISSUE_WIDTH-1:0] debugWb_o
);
    import cpuIsaPkg::*;
    import pipeTypesPkg::*;

    laneCmd_t    [ISSUE_WIDTH-1:0] laneCmd;
    laneResult_t [ISSUE_WIDTH-1:0] exResult;   // to forwarding and writeback
    regAddr_t    [RD_PORTS-1:0]    rdAddr;
    word_t       [RD_PORTS-1:0]    rdData;
    logic        [ISSUE_WIDTH-1:0] wrEn;
    regAddr_t    [ISSUE_WIDTH-1:0] wrAddr;
    word_t       [ISSUE_WIDTH-1:0] wrData;

    issueUnit issueUnit_inst (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .pairSlots_i  (pairSlots_i),
        .pairValid_i  (pairValid_i),
        .pairAccept_o (pairAccept_o),
        .exResult_i   (exResult),
        .rdAddr_o     (rdAddr),
        .rdData_i     (rdData),
        .laneCmd_o    (laneCmd)
    );

    // lane 0 master, lane 1 slave
    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : gLane
        aluLane aluLane_inst (
            .clk_i    (clk_i),
            .rstN_i   (rstN_i),
            .cmd_i    (laneCmd[l]),
            .result_o (exResult[l])
        );
    end

    writebackUnit writebackUnit_inst (
        .clk_i      (clk_i),
        .rstN_i     (rstN_i),
        .exResult_i (exResult),
        .wrEn_o     (wrEn),
        .wrAddr_o   (wrAddr),
        .wrData_o   (wrData),
        .debugWb_o  (debugWb_o)
    );

    regFile regFile_inst (
        .clk_i    (clk_i),
        .rstN_i   (rstN_i),
        .rdAddr_i (rdAddr),
        .rdData_o (rdData),
        .wrEn_i   (wrEn),
        .wrAddr_i (wrAddr),
        .wrData_i (wrData)
    );

endmodule

`default_nettype wire

//--- testbench/dualIssueCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module dualIssueCoreTb;
    import cpuIsaPkg::*;
    import pipeTypesPkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int TIMEOUT    = 50;     // cycles allowed per wait

    typedef struct packed {
        logic [2:0]     test;
        logic [1:0]     stalls;         // cycles with accept low
        word_t    [1:0] instr;
        wbTrace_t [1:0] exp;
    } stimRow_t;

    typedef struct packed {
        wbTrace_t    trace;
        logic [31:0] dueEdge;           // edge count when the trace must show
    } expTrace_t;

    logic                        clk_i;
    logic                        rstN_i;
    instSlot_t [ISSUE_WIDTH-1:0] pairSlots;
    logic                        pairValid;
    logic                        pairAccept;
    wbTrace_t  [ISSUE_WIDTH-1:0] debugWb;

    stimRow_t    stimTable[$];
    expTrace_t   expQ[ISSUE_WIDTH][$];
    logic [31:0] edgeCnt     = '0;
    int          errCount    = 0;
    int          checkCount  = 0;
    int          testsRun    = 0;
    int          testsFailed = 0;

    dualIssueCore dualIssueCore_inst (
        .clk_i        (clk_i),
        .rstN_i       (rstN_i),
        .pairSlots_i  (pairSlots),
        .pairValid_i  (pairValid),
        .pairAccept_o (pairAccept),
        .debugWb_o    (debugWb)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) edgeCnt <= edgeCnt + 1;

    function automatic word_t rType(regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                    logic [4:0] sh, logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iType(logic [5:0] op, regAddr_t rs, regAddr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic string testName(int test);
        case (test)
            1:       return "reset state";
            2:       return "independent immediates";
            3:       return "forwarded R-type";
            4:       return "intra-pair split";
            default: return "same destination and r0";
        endcase
    endfunction

    // pcs follow the row index, master at +0 and slave at +4
    task automatic addRow(input logic [2:0] test, input logic [1:0] stalls,
                          input word_t i0, input regAddr_t d0, input word_t v0,
                          input word_t i1, input regAddr_t d1, input word_t v1);
        stimRow_t r;
        word_t    pc;
        pc         = 32'hBFC0_0000 + 8 * stimTable.size();
        r.test     = test;
        r.stalls   = stalls;
        r.instr[0] = i0;
        r.instr[1] = i1;
        r.exp[0]   = '{pc: pc, wen: (d0 != '0) ? 4'hF : 4'h0, wnum: d0, wdata: v0};
        r.exp[1]   = '{pc: pc + 4, wen: (d1 != '0) ? 4'hF : 4'h0, wnum: d1, wdata: v1};
        stimTable.push_back(r);
    endtask

    task automatic buildTable();
        addRow(2, 0, iType(OP_ADDIU, 0, 1, 16'hFFFB), 1, 32'hFFFF_FFFB,
                     iType(OP_ORI, 0, 2, 16'h8001), 2, 32'h0000_8001);
        addRow(2, 0, iType(OP_LUI, 0, 3, 16'h1234), 3, 32'h1234_0000,
                     iType(OP_ADDIU, 0, 4, 16'h8000), 4, 32'hFFFF_8000);
        addRow(2, 0, iType(OP_ANDI, 1, 5, 16'hF0F0), 5, 32'h0000_F0F0,
                     iType(OP_XORI, 2, 6, 16'hFFFF), 6, 32'h0000_7FFE);
        addRow(2, 0, iType(OP_ADDIU, 3, 7, 16'hFFFF), 7, 32'h1233_FFFF,
                     iType(OP_XORI, 1, 8, 16'h00FF), 8, 32'hFFFF_FF04);
        // each pair feeds the next
        addRow(3, 0, iType(OP_ADDIU, 0, 9, 16'h0007), 9, 32'h0000_0007,
                     iType(OP_ADDIU, 0, 10, 16'hFFF8), 10, 32'hFFFF_FFF8);
        addRow(3, 0, rType(9, 10, 11, 0, FN_ADDU), 11, 32'hFFFF_FFFF,
                     rType(9, 10, 12, 0, FN_SUBU), 12, 32'h0000_000F);
        addRow(3, 0, rType(11, 12, 13, 0, FN_SLT), 13, 32'h0000_0001,
                     rType(11, 12, 14, 0, FN_SLTU), 14, 32'h0000_0000);
        addRow(3, 0, rType(11, 12, 15, 0, FN_AND), 15, 32'h0000_000F,
                     rType(13, 10, 16, 0, FN_OR), 16, 32'hFFFF_FFF9);
        addRow(3, 0, rType(15, 16, 17, 0, FN_XOR), 17, 32'hFFFF_FFF6,
                     rType(0, 15, 18, 4, FN_SLL), 18, 32'h0000_00F0);
        addRow(3, 0, rType(0, 17, 19, 8, FN_SRL), 19, 32'h00FF_FFFF,
                     rType(18, 17, 20, 0, FN_SLTU), 20, 32'h0000_0001);
        // slave reads the master's destination
        addRow(4, 1, iType(OP_ADDIU, 0, 21, 16'h0064), 21, 32'h0000_0064,
                     rType(21, 21, 22, 0, FN_ADDU), 22, 32'h0000_00C8);
        addRow(4, 1, rType(22, 21, 23, 0, FN_SUBU), 23, 32'h0000_0064,
                     rType(0, 23, 24, 2, FN_SLL), 24, 32'h0000_0190);
        addRow(5, 0, iType(OP_ADDIU, 0, 25, 16'h1111), 25, 32'h0000_1111,
                     iType(OP_ADDIU, 0, 25, 16'h2222), 25, 32'h0000_2222);
        addRow(5, 0, rType(25, 0, 26, 0, FN_OR), 26, 32'h0000_2222,
                     iType(OP_ADDIU, 0, 0, 16'h0055), 0, 32'h0000_0055);
        addRow(5, 0, rType(25, 25, 0, 0, FN_ADDU), 0, 32'h0000_4444,
                     rType(25, 0, 27, 0, FN_ADDU), 27, 32'h0000_2222);
        addRow(5, 0, rType(25, 0, 28, 0, FN_OR), 28, 32'h0000_2222,
                     rType(0, 0, 29, 0, FN_ADDU), 29, 32'h0000_0000);
    endtask

    task automatic pushExp(input int lane, input wbTrace_t t, input logic [31:0] due);
        expTrace_t e;
        e.trace = t;
        e.dueEdge = due;
        expQ[lane].push_back(e);
    endtask

    // wnum and wdata only matter when the entry writes
    task automatic checkLane(input int l);
        expTrace_t e;
        if (expQ[l].size() > 0 && expQ[l][0].dueEdge == edgeCnt) begin
            e = expQ[l].pop_front();
            checkCount++;
            assert (debugWb[l].wen == e.trace.wen && debugWb[l].pc == e.trace.pc &&
                    (e.trace.wen == 4'h0 || (debugWb[l].wnum == e.trace.wnum &&
                                             debugWb[l].wdata == e.trace.wdata)))
            else begin
                errCount++;
                $display("[ERROR] %0t: lane %0d pc %h got wen %h r%0d=%h, expected wen %h r%0d=%h",
                         $time, l, debugWb[l].pc, debugWb[l].wen, debugWb[l].wnum,
                         debugWb[l].wdata, e.trace.wen, e.trace.wnum, e.trace.wdata);
            end
        end else begin
            assert (debugWb[l].wen == 4'h0) else begin
                errCount++;
                $display("[ERROR] %0t: lane %0d unexpected trace at pc %h",
                         $time, l, debugWb[l].pc);
            end
        end
    endtask

    always @(negedge clk_i) begin
        if (rstN_i) begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                checkLane(l);
            end
        end
    end

    task automatic issueRow(input stimRow_t row);
        int   waitCnt;
        int   lowCnt;
        logic done;
        waitCnt = 0;
        lowCnt  = 0;
        done    = 1'b0;
        @(negedge clk_i);
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            pairSlots[s].pc    = row.exp[s].pc;
            pairSlots[s].instr = row.instr[s];
        end
        pairValid = 1'b1;
        while (!done && waitCnt < TIMEOUT) begin
            #1;     // decode settled, next edge still ahead
            if (lowCnt == 0) begin
                pushExp(0, row.exp[0], edgeCnt + 2);    // master issues on this edge either way
            end
            if (pairAccept) begin
                done = 1'b1;
                pushExp(1, row.exp[1], edgeCnt + 2);
            end else begin
                lowCnt++;
            end
            @(posedge clk_i);
            if (!done) begin
                @(negedge clk_i);
            end
            waitCnt++;
        end
        if (!done) begin
            errCount++;
            $display("Timed out waiting for the pair at pc %h to be accepted", row.exp[0].pc);
        end
        assert (lowCnt == row.stalls) else begin
            errCount++;
            $display("[ERROR] %0t: pair at pc %h held accept low %0d cycles, expected %0d",
                     $time, row.exp[0].pc, lowCnt, row.stalls);
        end
    endtask

    task automatic drainTraces();
        int waitCnt;
        waitCnt = 0;
        @(negedge clk_i);
        pairValid = 1'b0;
        #1;
        while ((expQ[0].size() + expQ[1].size()) > 0 && waitCnt < TIMEOUT) begin
            @(negedge clk_i);
            #1;
            waitCnt++;
        end
        if ((expQ[0].size() + expQ[1].size()) > 0) begin
            errCount++;
            $display("Timed out waiting for write-back traces, %0d still missing",
                     expQ[0].size() + expQ[1].size());
            expQ[0].delete();
            expQ[1].delete();
        end
    endtask

    task automatic reportTest(input int test, input int errBefore);
        testsRun++;
        if (errCount == errBefore) begin
            $display("test %0d (%s): passed", test, testName(test));
        end else begin
            testsFailed++;
            $display("test %0d (%s): FAILED, %0d errors", test, testName(test),
                     errCount - errBefore);
        end
    endtask

    initial begin
        int errBefore;
        $timeformat(-9, 1, " ns", 0);
        rstN_i    = 1'b0;
        pairValid = 1'b0;
        pairSlots = '0;
        buildTable();
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rstN_i = 1'b1;
        errBefore = errCount;
        repeat (2) @(negedge clk_i);
        #1;
        assert (pairAccept === 1'b1 && debugWb[0].wen == 4'h0 && debugWb[1].wen == 4'h0)
        else begin
            errCount++;
            $display("[ERROR] %0t: idle state after reset has accept %b wen %h/%h",
                     $time, pairAccept, debugWb[0].wen, debugWb[1].wen);
        end
        reportTest(1, errBefore);
        errBefore = errCount;
        foreach (stimTable[i]) begin
            issueRow(stimTable[i]);
            if (i == stimTable.size() - 1 || stimTable[i+1].test != stimTable[i].test) begin
                drainTraces();
                reportTest(stimTable[i].test, errBefore);
                errBefore = errCount;
            end
        end
        $display("%0d tests run, %0d failed, %0d trace checks, %0d errors",
                 testsRun, testsFailed, checkCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/cpuIsaPkg.sv
verilog/pipeTypesPkg.sv
verilog/issueUnit.sv
verilog/regFile.sv
verilog/aluLane.sv
verilog/writebackUnit.sv
verilog/dualIssueCore.sv
testbench/dualIssueCoreTb.sv

//--- Bender.yml
package:
  name: dual_issue_core

sources:
  - verilog/cpuIsaPkg.sv
  - verilog/pipeTypesPkg.sv
  - verilog/issueUnit.sv
  - verilog/regFile.sv
  - verilog/aluLane.sv
  - verilog/writebackUnit.sv
  - verilog/dualIssueCore.sv
  - target: test
    files:
      - testbench/dualIssueCoreTb.sv
